/* Bender.yml */
package:
  name: legalizer

sources:
  - hw/legalizer_pkg.sv
  - hw/page_boundary_calc.sv
  - hw/burst_chopper.sv
  - hw/legalizer_ctrl.sv
  - hw/legalizer_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_legalizer.sv

/* hw/burst_chopper.sv */
/*
 * Burst chopper
 * Holds the remaining part of one side's transfer and cuts off one legal
 * burst on every enabled clock edge
 */
`timescale 1ns/1ns

module burst_chopper
    import legalizer_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       load_i,
    input  len_t       length_i,
    input  addr_t      addr_i,
    input  burst_e     burst_i,
    input  logic       en_i,
    input  logic       kill_i,
    input  page_len_t  bytes_possible_i,
    output addr_t      addr_o,
    output burst_req_t burst_o,
    output logic       done_o,
    output logic       busy_o
);

    // ------------------------------
    // transfer state
    // ------------------------------
    len_t   len_q;
    addr_t  addr_q;
    burst_e burst_q;
    logic   valid_q;

    // bytes moved by the current burst
    page_len_t num_bytes;
    // remainder fits into the current burst
    logic fits;
    // first byte inside the first beat
    logic [OFFSET_WIDTH-1:0] addr_offset;
    // last byte position minus one relative to the first beat
    logic [PAGE_ADDR_WIDTH-1:0] span;

    // chop at the boundary or take whatever is left
    always_comb begin
        if (len_q > len_t'(bytes_possible_i)) begin
            num_bytes = bytes_possible_i;
            fits = 1'b0;
        end else begin
            num_bytes = len_q[PAGE_ADDR_WIDTH:0];
            fits = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            len_q <= '0;
            addr_q <= '0;
            burst_q <= INCR;
            valid_q <= 1'b0;
        end else if (load_i) begin
            // a new request wins over kill and advance
            len_q <= length_i;
            addr_q <= addr_i;
            burst_q <= burst_i;
            valid_q <= 1'b1;
        end else if (kill_i) begin
            len_q <= '0;
            addr_q <= '0;
            burst_q <= INCR;
            valid_q <= 1'b0;
        end else if (en_i) begin
            if (fits) begin
                // final burst goes out this cycle
                len_q <= '0;
                valid_q <= 1'b0;
            end else begin
                len_q <= len_q - len_t'(num_bytes);
                addr_q <= addr_q + addr_t'(num_bytes);
            end
        end
    end

    // ------------------------------
    // burst fields
    // ------------------------------
    assign addr_offset = addr_q[OFFSET_WIDTH-1:0];
    assign span = PAGE_ADDR_WIDTH'(num_bytes + page_len_t'(addr_offset) - page_len_t'(1));

    assign burst_o.addr = {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    // beats minus one
    assign burst_o.len = span[PAGE_ADDR_WIDTH-1:OFFSET_WIDTH];
    assign burst_o.burst = burst_q;
    assign burst_o.offset = addr_offset;
    // end byte wraps to zero on a full last beat
    assign burst_o.tailer = OFFSET_WIDTH'(num_bytes + page_len_t'(addr_offset));
    assign burst_o.last = done_o;

    // idle also counts as done so a new request can load
    assign done_o = ~valid_q | fits;
    assign busy_o = valid_q;
    assign addr_o = addr_q;

    // a held transfer always has bytes left to move
    a_valid_not_empty : assert property (
        @(posedge clk_i) disable iff (reset_i)
        valid_q |-> (len_q != '0)
    );

endmodule

/* hw/legalizer_ctrl.sv */
/*
 * Legalizer controller
 * Option register, coupled or decoupled page limits, enables, burst strobes
 * and request acceptance
 */
`timescale 1ns/1ns

module legalizer_ctrl
    import legalizer_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  xfer_opt_t req_opt_i,
    input  logic      valid_i,
    input  logic      r_ready_i,
    input  logic      w_ready_i,
    input  logic      kill_i,
    input  page_len_t r_bytes_to_pb_i,
    input  page_len_t w_bytes_to_pb_i,
    input  logic      r_done_i,
    input  logic      w_done_i,
    input  logic      r_busy_i,
    input  logic      w_busy_i,
    output logic      ready_o,
    output logic      load_o,
    output xfer_opt_t opt_o,
    output page_len_t r_bytes_possible_o,
    output page_len_t w_bytes_possible_o,
    output logic      r_en_o,
    output logic      w_en_o,
    output logic      r_valid_o,
    output logic      w_valid_o
);

    // options of the transfer in flight
    xfer_opt_t opt_q;
    // closer of the two boundaries
    page_len_t c_bytes_to_pb;

    // ------------------------------
    // option register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            opt_q <= '0;
        end else if (load_o) begin
            opt_q <= req_opt_i;
        end else if (kill_i) begin
            opt_q <= '0;
        end
    end

    assign opt_o = opt_q;

    // ------------------------------
    // page limits
    // ------------------------------
    // coupled sides step by the same amount, so both obey the nearer boundary
    assign c_bytes_to_pb = (r_bytes_to_pb_i > w_bytes_to_pb_i) ? w_bytes_to_pb_i
                                                               : r_bytes_to_pb_i;

    assign r_bytes_possible_o = opt_q.decouple_rw ? r_bytes_to_pb_i : c_bytes_to_pb;
    assign w_bytes_possible_o = opt_q.decouple_rw ? w_bytes_to_pb_i : c_bytes_to_pb;

    // ------------------------------
    // flow control
    // ------------------------------
    always_comb begin
        if (opt_q.decouple_rw) begin
            // each side only waits for its own channel
            r_en_o = r_ready_i;
            w_en_o = w_ready_i;
        end else begin
            // lockstep where either ready stalls both
            r_en_o = r_ready_i & w_ready_i;
            w_en_o = r_ready_i & w_ready_i;
        end
    end

    // one burst per enabled cycle while a side holds a transfer
    assign r_valid_o = r_busy_i & r_en_o;
    assign w_valid_o = w_busy_i & w_en_o;

    // take a new request once both last bursts leave
    assign ready_o = r_done_i & w_done_i & r_ready_i & w_ready_i;
    assign load_o = ready_o & valid_i;

    // ------------------------------
    // assertions
    // ------------------------------
    // only INCR bursts can be cut into pieces
    a_incr_only : assert property (
        @(posedge clk_i) disable iff (reset_i)
        load_o |-> (req_opt_i.src_burst == INCR) && (req_opt_i.dst_burst == INCR)
    );

    // a strobe for a non final burst leaves the chopper holding the rest
    a_r_valid_busy : assert property (
        @(posedge clk_i) disable iff (reset_i)
        r_valid_o && !r_done_i && !kill_i |=> r_busy_i
    );

    a_w_valid_busy : assert property (
        @(posedge clk_i) disable iff (reset_i)
        w_valid_o && !w_done_i && !kill_i |=> w_busy_i
    );

endmodule

/* hw/legalizer_pkg.sv */
/*
 * Legalizer package
 * Widths, constants and the request, option and burst structs shared by
 * the AXI4 transfer legalizer of the DMA back-end
 */
package legalizer_pkg;

    // ------------------------------
    // bus and address geometry
    // ------------------------------
    // byte address and transfer length widths
    localparam int unsigned ADDR_WIDTH = 24;
    localparam int unsigned LEN_WIDTH = 24;

    // data bus, one beat carries STRB_WIDTH bytes
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;
    // byte select bits inside one beat
    localparam int unsigned OFFSET_WIDTH = $clog2(STRB_WIDTH);

    // AXI4 limit on INCR bursts
    localparam int unsigned MAX_BEATS = 256;
    // log2 beat count used when no reduction is requested
    localparam int unsigned FULL_LLEN = $clog2(MAX_BEATS);
    // a page is one maximum burst, 1 KiB on a 32 bit bus
    localparam int unsigned PAGE_ADDR_WIDTH = $clog2(MAX_BEATS * STRB_WIDTH);

    // ------------------------------
    // scalar types
    // ------------------------------
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LEN_WIDTH-1:0] len_t;
    // one extra bit so that a full page fits
    typedef logic [PAGE_ADDR_WIDTH:0] page_len_t;
    // log2 of the reduced beat count
    typedef logic [2:0] llen_t;

    // AXI burst type encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR = 2'b01,
        WRAP = 2'b10
    } burst_e;

    // ------------------------------
    // request side
    // ------------------------------
    // per request options, kept for the whole transfer
    typedef struct packed {
        logic decouple_rw;
        logic src_reduce_len;
        llen_t src_max_llen;
        logic dst_reduce_len;
        llen_t dst_max_llen;
        burst_e src_burst;
        burst_e dst_burst;
    } xfer_opt_t;

    // one linear copy
    typedef struct packed {
        len_t length;
        addr_t src_addr;
        addr_t dst_addr;
        xfer_opt_t opt;
    } xfer_req_t;

    // ------------------------------
    // burst side
    // ------------------------------
    // one legal burst, addr is beat aligned, len is beats minus one
    typedef struct packed {
        addr_t addr;
        logic [7:0] len;
        burst_e burst;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [OFFSET_WIDTH-1:0] tailer;
        logic last;
    } burst_req_t;

endpackage

/* hw/legalizer_top.sv */
/*
 * AXI4 transfer legalizer
 * Cuts one linear copy into legal read and write bursts
 */
`timescale 1ns/1ns

module legalizer_top
    import legalizer_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  xfer_req_t  req_i,
    input  logic       valid_i,
    output logic       ready_o,
    output burst_req_t r_req_o,
    output logic       r_valid_o,
    input  logic       r_ready_i,
    output burst_req_t w_req_o,
    output logic       w_valid_o,
    input  logic       w_ready_i,
    input  logic       kill_i,
    output logic       r_busy_o,
    output logic       w_busy_o
);

    // current addresses of both sides
    addr_t r_addr;
    addr_t w_addr;
    // distance to each side's own boundary
    page_len_t r_bytes_to_pb;
    page_len_t w_bytes_to_pb;
    // limits after coupling
    page_len_t r_bytes_possible;
    page_len_t w_bytes_possible;

    logic r_en;
    logic w_en;
    logic r_done;
    logic w_done;
    logic load;
    // options of the running transfer
    xfer_opt_t opt;

    // ------------------------------
    // read side
    // ------------------------------
    page_boundary_calc u_r_page (
        .addr_i        (r_addr),
        .reduce_len_i  (opt.src_reduce_len),
        .max_llen_i    (opt.src_max_llen),
        .bytes_to_pb_o (r_bytes_to_pb)
    );

    burst_chopper u_r_chop (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .load_i           (load),
        .length_i         (req_i.length),
        .addr_i           (req_i.src_addr),
        .burst_i          (req_i.opt.src_burst),
        .en_i             (r_en),
        .kill_i           (kill_i),
        .bytes_possible_i (r_bytes_possible),
        .addr_o           (r_addr),
        .burst_o          (r_req_o),
        .done_o           (r_done),
        .busy_o           (r_busy_o)
    );

    // ------------------------------
    // write side
    // ------------------------------
    page_boundary_calc u_w_page (
        .addr_i        (w_addr),
        .reduce_len_i  (opt.dst_reduce_len),
        .max_llen_i    (opt.dst_max_llen),
        .bytes_to_pb_o (w_bytes_to_pb)
    );

    burst_chopper u_w_chop (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .load_i           (load),
        .length_i         (req_i.length),
        .addr_i           (req_i.dst_addr),
        .burst_i          (req_i.opt.dst_burst),
        .en_i             (w_en),
        .kill_i           (kill_i),
        .bytes_possible_i (w_bytes_possible),
        .addr_o           (w_addr),
        .burst_o          (w_req_o),
        .done_o           (w_done),
        .busy_o           (w_busy_o)
    );

    // ------------------------------
    // control
    // ------------------------------
    legalizer_ctrl u_ctrl (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .req_opt_i          (req_i.opt),
        .valid_i            (valid_i),
        .r_ready_i          (r_ready_i),
        .w_ready_i          (w_ready_i),
        .kill_i             (kill_i),
        .r_bytes_to_pb_i    (r_bytes_to_pb),
        .w_bytes_to_pb_i    (w_bytes_to_pb),
        .r_done_i           (r_done),
        .w_done_i           (w_done),
        .r_busy_i           (r_busy_o),
        .w_busy_i           (w_busy_o),
        .ready_o            (ready_o),
        .load_o             (load),
        .opt_o              (opt),
        .r_bytes_possible_o (r_bytes_possible),
        .w_bytes_possible_o (w_bytes_possible),
        .r_en_o             (r_en),
        .w_en_o             (w_en),
        .r_valid_o          (r_valid_o),
        .w_valid_o          (w_valid_o)
    );

endmodule

/* hw/page_boundary_calc.sv */
/*
 * Page boundary calculator
 * Bytes left from an address to the next (possibly reduced) page boundary
 */
`timescale 1ns/1ns

module page_boundary_calc
    import legalizer_pkg::*;
(
    input  addr_t     addr_i,
    input  logic      reduce_len_i,
    input  llen_t     max_llen_i,
    output page_len_t bytes_to_pb_o
);

    // effective page width in address bits, at most PAGE_ADDR_WIDTH
    logic [3:0] page_width;
    // page size in bytes for that width
    page_len_t page_size;
    // address bits below the effective page width
    logic [PAGE_ADDR_WIDTH-1:0] page_offset;

    // ------------------------------
    // page width
    // ------------------------------
    always_comb begin
        // reduced pages shrink the burst to 2**max_llen beats
        if (reduce_len_i) begin
            page_width = 4'(OFFSET_WIDTH) + 4'(max_llen_i);
        end else begin
            page_width = 4'(OFFSET_WIDTH) + 4'(FULL_LLEN);
        end
        // never beyond the AXI page
        if (page_width > 4'(PAGE_ADDR_WIDTH)) begin
            page_width = 4'(PAGE_ADDR_WIDTH);
        end
    end

    assign page_size = page_len_t'(1) << page_width;

    // ------------------------------
    // variable width address mask
    // ------------------------------
    // part select cannot take a variable width, so mask bit by bit
    always_comb begin
        for (int i = 0; i < PAGE_ADDR_WIDTH; i++) begin
            page_offset[i] = (page_width > 4'(i)) ? addr_i[i] : 1'b0;
        end
    end

    // distance to the boundary, a full page when already aligned
    assign bytes_to_pb_o = page_size - page_len_t'(page_offset);

endmodule

/* project.f */
+incdir+verif
hw/legalizer_pkg.sv
hw/page_boundary_calc.sv
hw/burst_chopper.sv
hw/legalizer_ctrl.sv
hw/legalizer_top.sv
verif/tb_legalizer.sv

/* verif/tb_legalizer_tasks.svh */
/*
 * Reference burst model and directed tests for the legalizer testbench
 */
`ifndef TB_LEGALIZER_TASKS_SVH
`define TB_LEGALIZER_TASKS_SVH

    // ------------------------------
    // reference model
    // ------------------------------
    // bytes up to the next page boundary, page is 2**llen beats when reduced
    function automatic int unsigned bytes_to_page(addr_t addr, logic reduce, llen_t llen);
        int unsigned width;
        int unsigned page;
        if (reduce) begin
            width = OFFSET_WIDTH + int'(llen);
        end else begin
            width = OFFSET_WIDTH + FULL_LLEN;
        end
        if (width > PAGE_ADDR_WIDTH) begin
            width = PAGE_ADDR_WIDTH;
        end
        page = 1 << width;
        return page - (int'(addr) % page);
    endfunction

    // burst fields for n bytes starting at addr
    function automatic burst_req_t make_burst(addr_t addr, int unsigned n, logic last);
        burst_req_t b;
        int unsigned off;
        off = int'(addr) % STRB_WIDTH;
        b.addr = addr - addr_t'(off);
        b.len = 8'((n + off - 1) / STRB_WIDTH);
        b.burst = INCR;
        b.offset = OFFSET_WIDTH'(off);
        b.tailer = OFFSET_WIDTH'((n + off) % STRB_WIDTH);
        b.last = last;
        return b;
    endfunction

    function automatic void reserve_cycles(int unsigned bursts);
        cycle_limit += 20 * bursts;
    endfunction

    // coupled sides both step by the nearer boundary
    function automatic void build_expected(xfer_req_t req);
        addr_t ra;
        addr_t wa;
        int unsigned rem_r;
        int unsigned rem_w;
        int unsigned lim_r;
        int unsigned lim_w;
        int unsigned n;
        exp_r.delete();
        exp_w.delete();
        ra = req.src_addr;
        wa = req.dst_addr;
        rem_r = req.length;
        rem_w = req.length;
        while (rem_r > 0 || rem_w > 0) begin
            lim_r = bytes_to_page(ra, req.opt.src_reduce_len, req.opt.src_max_llen);
            lim_w = bytes_to_page(wa, req.opt.dst_reduce_len, req.opt.dst_max_llen);
            if (!req.opt.decouple_rw) begin
                if (lim_w < lim_r) begin
                    lim_r = lim_w;
                end
                lim_w = lim_r;
            end
            if (rem_r > 0) begin
                n = (rem_r < lim_r) ? rem_r : lim_r;
                exp_r.push_back(make_burst(ra, n, rem_r <= lim_r));
                ra = ra + addr_t'(n);
                rem_r -= n;
            end
            if (rem_w > 0) begin
                n = (rem_w < lim_w) ? rem_w : lim_w;
                exp_w.push_back(make_burst(wa, n, rem_w <= lim_w));
                wa = wa + addr_t'(n);
                rem_w -= n;
            end
        end
        reserve_cycles(exp_r.size() + exp_w.size());
    endfunction

    // ------------------------------
    // drivers and bookkeeping
    // ------------------------------
    function automatic xfer_req_t make_req(len_t length, addr_t src, addr_t dst,
                                           logic decouple);
        xfer_req_t req;
        req = '0;
        req.length = length;
        req.src_addr = src;
        req.dst_addr = dst;
        req.opt.decouple_rw = decouple;
        req.opt.src_burst = INCR;
        req.opt.dst_burst = INCR;
        return req;
    endfunction

    // beat aligned burst written out by hand
    function automatic burst_req_t aligned_burst(addr_t addr, int unsigned len, logic last);
        burst_req_t b;
        b = '0;
        b.addr = addr;
        b.len = 8'(len);
        b.burst = INCR;
        b.last = last;
        return b;
    endfunction

    // returns on the falling edge after acceptance
    task automatic send_req(xfer_req_t req);
        @(negedge clk_i);
        req_i = req;
        valid_i = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!ready_o);
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk_i);
        end while (r_busy_o || w_busy_o);
    endtask

    task automatic compare_side(string name, string side, burst_req_t expected[$],
                                burst_req_t actual[$]);
        check_count++;
        if (expected.size() != actual.size()) begin
            error_count++;
            $display("%s: %s side emitted %0d bursts but %0d were expected",
                     name, side, actual.size(), expected.size());
        end else begin
            foreach (expected[i]) begin
                compare_burst($sformatf("%s %s burst %0d", name, side, i),
                              expected[i], actual[i]);
            end
        end
    endtask

    // compares both channels and empties all queues
    task automatic check_bursts(string name);
        compare_side(name, "read", exp_r, rd_q);
        compare_side(name, "write", exp_w, wr_q);
        rd_q.delete();
        wr_q.delete();
        exp_r.delete();
        exp_w.delete();
    endtask

    task automatic finish_test(string name, int unsigned errors_before);
        tests_done++;
        if (error_count == errors_before) begin
            $display("test %-16s passed", name);
        end else begin
            $display("test %-16s failed, %0d bad checks", name, error_count - errors_before);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic reset_state();
        int unsigned errors_before;
        errors_before = error_count;
        @(negedge clk_i);
        compare_bit("reset_state ready", 1'b1, ready_o);
        compare_bit("reset_state r_valid", 1'b0, r_valid_o);
        compare_bit("reset_state w_valid", 1'b0, w_valid_o);
        compare_bit("reset_state r_busy", 1'b0, r_busy_o);
        compare_bit("reset_state w_busy", 1'b0, w_busy_o);
        finish_test("reset_state", errors_before);
    endtask

    // 64 bytes fit in a single 16 beat burst per side
    task automatic aligned_copy();
        int unsigned errors_before;
        errors_before = error_count;
        exp_r.push_back(aligned_burst(24'h100, 15, 1'b1));
        exp_w.push_back(aligned_burst(24'h800, 15, 1'b1));
        reserve_cycles(2);
        send_req(make_req(24'd64, 24'h100, 24'h800, 1'b0));
        wait_idle();
        check_bursts("aligned_copy");
        finish_test("aligned_copy", errors_before);
    endtask

    // source hits its page end after 8 bytes, write follows in lockstep
    task automatic page_split();
        int unsigned errors_before;
        errors_before = error_count;
        exp_r.push_back(aligned_burst(24'h3F8, 1, 1'b0));
        exp_r.push_back(aligned_burst(24'h400, 7, 1'b1));
        exp_w.push_back(aligned_burst(24'h000, 1, 1'b0));
        exp_w.push_back(aligned_burst(24'h008, 7, 1'b1));
        reserve_cycles(4);
        send_req(make_req(24'd40, 24'h3F8, 24'h000, 1'b0));
        wait_idle();
        check_bursts("page_split");
        finish_test("page_split", errors_before);
    endtask

    // 16 byte read pages, write keeps full pages in decoupled mode
    task automatic reduced_source();
        xfer_req_t req;
        int unsigned errors_before;
        errors_before = error_count;
        req = make_req(24'd100, 24'h204, 24'h400, 1'b1);
        req.opt.src_reduce_len = 1'b1;
        req.opt.src_max_llen = 3'd2;
        build_expected(req);
        send_req(req);
        wait_idle();
        foreach (rd_q[i]) begin
            compare_bit($sformatf("reduced_source read %0d short", i), 1'b1, rd_q[i].len < 4);
        end
        check_bursts("reduced_source");
        finish_test("reduced_source", errors_before);
    endtask

    // read side runs to completion while the write channel stalls
    task automatic decoupled_stall();
        xfer_req_t req;
        int unsigned errors_before;
        errors_before = error_count;
        req = make_req(24'd3000, 24'h000, 24'h1000, 1'b1);
        build_expected(req);
        send_req(req);
        w_ready_i = 1'b0;
        do begin
            @(negedge clk_i);
        end while (r_busy_o);
        compare_bit("decoupled_stall w_busy", 1'b1, w_busy_o);
        if (wr_q.size() != 0) begin
            error_count++;
            $display("decoupled_stall: write bursts came out while w_ready was low");
        end
        w_ready_i = 1'b1;
        wait_idle();
        check_bursts("decoupled_stall");
        finish_test("decoupled_stall", errors_before);
    endtask

    // one low ready holds both sides
    task automatic coupled_stall();
        xfer_req_t req;
        int unsigned errors_before;
        errors_before = error_count;
        req = make_req(24'd100, 24'h010, 24'h3F0, 1'b0);
        build_expected(req);
        send_req(req);
        w_ready_i = 1'b0;
        repeat (8) @(negedge clk_i);
        compare_bit("coupled_stall r_busy", 1'b1, r_busy_o);
        compare_bit("coupled_stall w_busy", 1'b1, w_busy_o);
        if (rd_q.size() != 0 || wr_q.size() != 0) begin
            error_count++;
            $display("coupled_stall: bursts came out while w_ready was low");
        end
        w_ready_i = 1'b1;
        wait_idle();
        check_bursts("coupled_stall");
        finish_test("coupled_stall", errors_before);
    endtask

    // two bursts per side leave before the kill edge clears the choppers
    task automatic kill_midway();
        xfer_req_t req;
        int unsigned errors_before;
        errors_before = error_count;
        req = make_req(24'd4096, 24'h000, 24'h2000, 1'b0);
        build_expected(req);
        send_req(req);
        @(negedge clk_i);
        kill_i = 1'b1;
        @(negedge clk_i);
        kill_i = 1'b0;
        compare_bit("kill_midway r_busy", 1'b0, r_busy_o);
        compare_bit("kill_midway w_busy", 1'b0, w_busy_o);
        while (exp_r.size() > 2) begin
            void'(exp_r.pop_back());
        end
        while (exp_w.size() > 2) begin
            void'(exp_w.pop_back());
        end
        check_bursts("kill_midway");
        // the next request must not see any leftover state
        req = make_req(24'd200, 24'h1F2, 24'h7C0, 1'b1);
        build_expected(req);
        send_req(req);
        wait_idle();
        check_bursts("kill_midway after");
        finish_test("kill_midway", errors_before);
    endtask

    task automatic random_requests();
        xfer_req_t req;
        int unsigned errors_before;
        errors_before = error_count;
        for (int i = 0; i < 20; i++) begin
            req = make_req(len_t'(($random(seed) & 32'h7FF) + 1),
                           addr_t'($random(seed) & 32'hFFFF),
                           addr_t'($random(seed) & 32'hFFFF),
                           1'($random(seed)));
            req.opt.src_reduce_len = 1'($random(seed));
            req.opt.src_max_llen = llen_t'($random(seed));
            req.opt.dst_reduce_len = 1'($random(seed));
            req.opt.dst_max_llen = llen_t'($random(seed));
            build_expected(req);
            send_req(req);
            wait_idle();
            check_bursts($sformatf("random_requests %0d", i));
        end
        finish_test("random_requests", errors_before);
    endtask

`endif

/* verif/tb_legalizer.sv */
/*
 * Testbench for the AXI4 transfer legalizer
 * Clock, reset, DUT, burst monitors, checkers, timeout and test sequence
 */
`timescale 1ns/1ns

module tb_legalizer
    import legalizer_pkg::*;
();

    logic       clk_i;
    logic       reset_i;
    xfer_req_t  req_i;
    logic       valid_i;
    logic       ready_o;
    burst_req_t r_req_o;
    logic       r_valid_o;
    logic       r_ready_i;
    burst_req_t w_req_o;
    logic       w_valid_o;
    logic       w_ready_i;
    logic       kill_i;
    logic       r_busy_o;
    logic       w_busy_o;

    // bursts seen on each channel
    burst_req_t rd_q[$];
    burst_req_t wr_q[$];
    // bursts the reference model predicts
    burst_req_t exp_r[$];
    burst_req_t exp_w[$];

    int unsigned error_count = 0;
    int unsigned check_count = 0;
    int unsigned tests_done = 0;
    // grows by 20 cycles for every expected burst
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 200;
    integer seed = 40;

    // ------------------------------
    // clock and DUT
    // ------------------------------
    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    legalizer_top u_legalizer_top (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .r_req_o   (r_req_o),
        .r_valid_o (r_valid_o),
        .r_ready_i (r_ready_i),
        .w_req_o   (w_req_o),
        .w_valid_o (w_valid_o),
        .w_ready_i (w_ready_i),
        .kill_i    (kill_i),
        .r_busy_o  (r_busy_o),
        .w_busy_o  (w_busy_o)
    );

    // ------------------------------
    // monitors and timeout
    // ------------------------------
    // a burst leaves on every edge where its strobe is high
    always @(posedge clk_i) begin
        if (!reset_i && r_valid_o) begin
            rd_q.push_back(r_req_o);
        end
        if (!reset_i && w_valid_o) begin
            wr_q.push_back(w_req_o);
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped emitting bursts", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------
    // checkers
    // ------------------------------
    function automatic string format_burst(burst_req_t b);
        return $sformatf("{addr=%h len=%0d burst=%0d off=%0d tail=%0d last=%b}",
                         b.addr, b.len, b.burst, b.offset, b.tailer, b.last);
    endfunction

    task automatic compare_burst(string name, burst_req_t expected, burst_req_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAIL %s expected %s actual %s", name,
                     format_burst(expected), format_burst(actual));
        end
    endtask

    task automatic compare_bit(string name, logic expected, logic actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAIL %s expected %b actual %b", name, expected, actual);
        end
    endtask

    `include "tb_legalizer_tasks.svh"

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        reset_i = 1'b1;
        req_i = '0;
        valid_i = 1'b0;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;
        kill_i = 1'b0;
        repeat (10) @(negedge clk_i);
        reset_i = 1'b0;
        reset_state();
        aligned_copy();
        page_split();
        reduced_source();
        decoupled_stall();
        coupled_stall();
        kill_midway();
        random_requests();
        $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
